// File: build.f
+incdir+include
+incdir+testbench
verilog/twofish_pkg.sv
verilog/q_permute.sv
verilog/h_function.sv
verilog/key_words.sv
verilog/key_schedule.sv
verilog/round_function.sv
verilog/twofish_ctrl.sv
verilog/twofish_core.sv
testbench/twofish_tb.sv

// File: Bender.yml
package:
  name: twofish_core

sources:
  - include_dirs:
      - include
    files:
      - verilog/twofish_pkg.sv
      - verilog/q_permute.sv
      - verilog/h_function.sv
      - verilog/key_words.sv
      - verilog/key_schedule.sv
      - verilog/round_function.sv
      - verilog/twofish_ctrl.sv
      - verilog/twofish_core.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/twofish_tb.sv

// File: testbench/twofish_vectors.svh
/*
 * Twofish-128 known answers from the iterated ECB chain.
 * Byte-reversed so byte 0 of the published stream lands in bits 7:0.
 */
`ifndef TWOFISH_VECTORS_SVH
`define TWOFISH_VECTORS_SVH

// columns: cipher key, plaintext, expected ciphertext
typedef struct packed {
    key_t   cipher_key;
    block_t pt;
    block_t ct;
} kat_t;

localparam int NUM_KAT = 3;

localparam kat_t KAT [NUM_KAT] = '{
    // zero key, zero plaintext
    '{cipher_key: 128'h00000000_00000000_00000000_00000000,
      pt:         128'h00000000_00000000_00000000_00000000,
      ct:         128'h5AC3E82A_2FECBFB6_322C12F6_5C9F589F},
    // zero key, previous ciphertext as plaintext
    '{cipher_key: 128'h00000000_00000000_00000000_00000000,
      pt:         128'h5AC3E82A_2FECBFB6_322C12F6_5C9F589F,
      ct:         128'h19549F78_6B08CB86_9EC3B1E7_16DB91D4},
    // chain continues with the first ciphertext as key
    '{cipher_key: 128'h5AC3E82A_2FECBFB6_322C12F6_5C9F589F,
      pt:         128'h19549F78_6B08CB86_9EC3B1E7_16DB91D4,
      ct:         128'hC3FB20BA_A3C3AA8F_851117DE_09989F01}
};

`endif

// File: testbench/twofish_tb.sv
/*
 * Testbench for twofish_core: known answers both ways, random round trips
 * and req/ack timing with back-pressure. Inputs change on the falling edge.
 */
`timescale 1ns/1ps

module twofish_tb import twofish_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int ACK_LATENCY  = 18;
    localparam int HOLD_CYCLES  = 10;
    localparam int ACK_TIMEOUT  = 40;
    localparam int NUM_RANDOM   = 4;

    `include "twofish_vectors.svh"

    localparam int NUM_VECTORS = NUM_KAT + NUM_RANDOM;
    localparam int WATCHDOG_NS = (NUM_VECTORS * 2 * 30 + RESET_CYCLES) * CLK_PERIOD;

    logic   clk = 1'b0;
    logic   rst;
    logic   req;
    logic   decrypt;
    key_t   key;
    block_t text_in;
    logic   ack;
    block_t text_out;

    int errors;
    int checks;
    int seed = 32'h8b113031;

    twofish_core #(.rounds(16)) i_twofish_core (
        .clk(clk),
        .rst(rst),
        .req(req),
        .decrypt(decrypt),
        .key(key),
        .text_in(text_in),
        .ack(ack),
        .text_out(text_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_block(input string what, input block_t got, input block_t exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH text_out (%s) got %h expected %h", what, got, exp);
            errors++;
        end
    endtask

    task automatic check_ack(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH ack got %h expected %h at %0t", got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("MISMATCH ack latency got %0h expected %0h", got, exp);
            errors++;
        end
    endtask

    // one full handshake, entered and left just after a falling edge
    task automatic run_block(input key_t k, input logic dec, input block_t din,
                             input int hold, output block_t dout);
        int waited;
        key     = k;
        decrypt = dec;
        text_in = din;
        req     = 1'b1;
        waited  = 0;
        @(negedge clk);
        // waited counts rising edges after the one that saw req
        while (ack !== 1'b1 && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (ack !== 1'b1) begin
            $display("ack did not rise within %0d cycles of req", ACK_TIMEOUT);
            errors++;
        end else begin
            check_latency(waited, ACK_LATENCY);
        end
        dout = text_out;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_ack(ack, 1'b1);
            check_block("held", text_out, dout);
        end
        req = 1'b0;
        @(negedge clk);
        check_ack(ack, 1'b0);
    endtask

    initial begin
        block_t got;
        block_t ct;
        block_t pt;
        key_t   rkey;
        errors  = 0;
        checks  = 0;
        rst     = 1'b1;
        req     = 1'b0;
        decrypt = 1'b0;
        key     = '0;
        text_in = '0;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_ack(ack, 1'b0);
        end
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_ack(ack, 1'b0);
        end

        // first encryption also holds req to check back-pressure
        for (int v = 0; v < NUM_KAT; v++) begin
            run_block(KAT[v].cipher_key, 1'b0, KAT[v].pt, (v == 0) ? HOLD_CYCLES : 0, got);
            check_block("encrypt", got, KAT[v].ct);
            run_block(KAT[v].cipher_key, 1'b1, KAT[v].ct, 0, got);
            check_block("decrypt", got, KAT[v].pt);
        end

        for (int v = 0; v < NUM_RANDOM; v++) begin
            rkey = {$random(seed), $random(seed), $random(seed), $random(seed)};
            pt   = {$random(seed), $random(seed), $random(seed), $random(seed)};
            run_block(rkey, 1'b0, pt, 0, ct);
            run_block(rkey, 1'b1, ct, 0, got);
            check_block("round trip", got, pt);
        end

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog sized from the vector count
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not complete within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verilog/twofish_core.sv
/*
 * Iterative Twofish, 128-bit key, encrypt or decrypt by the decrypt bit.
 * key must stay stable for the whole request, one block in flight.
 */
`timescale 1ns/1ps

module twofish_core import twofish_pkg::*; #(
    parameter int rounds = 16
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   req,
    input  logic   decrypt,
    input  key_t   key,
    input  block_t text_in,
    output logic   ack,
    output block_t text_out
);

    sbox_key_t  keys;
    whiten_t    whiten;
    block_t     cur;
    block_t     nxt;
    round_idx_t round_idx;

    key_schedule i_key_schedule (
        .key(key),
        .keys(keys),
        .whiten(whiten)
    );

    round_function i_round_function (
        .decrypt(decrypt),
        .round_idx(round_idx),
        .keys(keys),
        .cur(cur),
        .nxt(nxt)
    );

    twofish_ctrl #(.rounds(rounds)) i_twofish_ctrl (
        .clk(clk),
        .rst(rst),
        .req(req),
        .decrypt(decrypt),
        .text_in(text_in),
        .whiten(whiten),
        .nxt(nxt),
        .round_idx(round_idx),
        .cur(cur),
        .ack(ack),
        .text_out(text_out)
    );

endmodule

// File: verilog/twofish_ctrl.sv
/*
 * Four-phase req/ack sequencer with block register and round counter.
 * One block at a time: load, rounds cycles, output whitening, then ack.
 * decrypt and text_in must be held from req until ack.
 */
`timescale 1ns/1ps

module twofish_ctrl import twofish_pkg::*; #(
    parameter int rounds = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       req,
    input  logic       decrypt,
    input  block_t     text_in,
    input  whiten_t    whiten,
    input  block_t     nxt,
    output round_idx_t round_idx,
    output block_t     cur,
    output logic       ack,
    output block_t     text_out
);

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_round,
        st_finish,
        st_done
    } state_t;

    localparam round_idx_t LAST_IDX = round_idx_t'(rounds - 1);

    state_t     state;
    round_idx_t cnt;
    block_t     blk;
    block_t     in_white;
    block_t     out_white;
    logic       last_round;

    // encryption whitens with k0..k3 going in and k4..k7 going out
    assign in_white  = decrypt ? {whiten.k7, whiten.k6, whiten.k5, whiten.k4}
                               : {whiten.k3, whiten.k2, whiten.k1, whiten.k0};
    assign out_white = decrypt ? {whiten.k3, whiten.k2, whiten.k1, whiten.k0}
                               : {whiten.k7, whiten.k6, whiten.k5, whiten.k4};

    assign last_round = decrypt ? (cnt == '0) : (cnt == LAST_IDX);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        state <= st_load;
                    end
                end
                st_load: begin
                    state <= st_round;
                    cnt   <= decrypt ? LAST_IDX : '0;
                end
                st_round: begin
                    if (last_round) begin
                        state <= st_finish;
                    end else begin
                        cnt <= decrypt ? cnt - 1'b1 : cnt + 1'b1;
                    end
                end
                st_finish: begin
                    state <= st_done;
                end
                st_done: begin
                    // hold the result until the master lets go
                    if (!req) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_load:   blk <= text_in ^ in_white;
            st_round:  blk <= nxt;
            // undo the swap of the last round
            st_finish: blk <= {blk.r1, blk.r0, blk.r3, blk.r2} ^ out_white;
            default:   blk <= blk;
        endcase
    end

    assign round_idx = cnt;
    assign cur       = blk;
    assign text_out  = blk;
    assign ack       = (state == st_done);

    a_ack_held: assert property (@(posedge clk) disable iff (rst)
        ack && req |=> ack && $stable(text_out))
        else $error("ack or text_out changed while req still high");

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        req && !ack |=> !req || ($stable(decrypt) && $stable(text_in)))
        else $error("request inputs changed before ack");

endmodule

// File: verilog/round_function.sv
/*
 * One Twofish Feistel round, forward or inverse by decrypt.
 * Output block holds the updated pair in r1:r0 and the old r1:r0 in r3:r2.
 */
`timescale 1ns/1ps

module round_function import twofish_pkg::*; (
    input  logic       decrypt,
    input  round_idx_t round_idx,
    input  sbox_key_t  keys,
    input  block_t     cur,
    output block_t     nxt
);

    round_idx_t key_idx;
    round_key_t rk;
    word_t      t0;
    word_t      t1;
    word_t      f0;
    word_t      f1;
    word_t      enc_r2;
    word_t      dec_r3;
    word_t      new_r2;
    word_t      new_r3;

    assign key_idx = round_idx + ROUND_KEY_BASE;

    h_function i_h_t0 (
        .x(cur.r0),
        .l1(keys.s1),
        .l0(keys.s0),
        .z(t0)
    );

    h_function i_h_t1 (
        .x({cur.r1[23:0], cur.r1[31:24]}),
        .l1(keys.s1),
        .l0(keys.s0),
        .z(t1)
    );

    key_words i_key_words (
        .pair_idx(key_idx),
        .keys(keys),
        .rk(rk)
    );

    // PHT plus round keys
    assign f0 = t0 + t1 + rk.k_even;
    assign f1 = t0 + {t1[30:0], 1'b0} + rk.k_odd;

    assign enc_r2 = cur.r2 ^ f0;
    assign dec_r3 = cur.r3 ^ f1;

    // inverse round swaps which side of the XOR each rotation sits on
    assign new_r2 = decrypt ? ({cur.r2[30:0], cur.r2[31]} ^ f0) : {enc_r2[0], enc_r2[31:1]};
    assign new_r3 = decrypt ? {dec_r3[0], dec_r3[31:1]} : ({cur.r3[30:0], cur.r3[31]} ^ f1);

    assign nxt = '{r3: cur.r1, r2: cur.r0, r1: new_r3, r0: new_r2};

endmodule

// File: verilog/key_schedule.sv
/*
 * Combinational key schedule for a 128-bit key: key words, RS S-box key
 * and the eight whitening words. Result settles only after the key is stable.
 */
`timescale 1ns/1ps

module key_schedule import twofish_pkg::*; (
    input  key_t      key,
    output sbox_key_t keys,
    output whiten_t   whiten
);

    round_key_t pair_keys [4];
    // RS over key bytes 0..7 and 8..15
    word_t      s_lo;
    word_t      s_hi;

    always_comb begin
        s_lo = '0;
        s_hi = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 8; c++) begin
                s_lo[8*r +: 8] = s_lo[8*r +: 8] ^ gf_mul(RS[r][c], key[8*c +: 8], RS_POLY);
                s_hi[8*r +: 8] = s_hi[8*r +: 8] ^ gf_mul(RS[r][c], key[64 + 8*c +: 8], RS_POLY);
            end
        end
    end

    // S-box key list is reversed, so the low half keys the first h layer
    assign keys = '{me1: key[95:64], me0: key[31:0], mo1: key[127:96], mo0: key[63:32],
                    s1: s_lo, s0: s_hi};

    for (genvar p = 0; p < 4; p++) begin : g_pair
        key_words i_key_words (
            .pair_idx(round_idx_t'(p)),
            .keys(keys),
            .rk(pair_keys[p])
        );
    end

    assign whiten = {pair_keys[3].k_odd, pair_keys[3].k_even,
                     pair_keys[2].k_odd, pair_keys[2].k_even,
                     pair_keys[1].k_odd, pair_keys[1].k_even,
                     pair_keys[0].k_odd, pair_keys[0].k_even};

    // a known key must resolve through RS and all four key word pairs
    a_outputs_known: assert final ($isunknown(key) || !$isunknown({keys, whiten}))
        else $error("key schedule output has unknown bits for a known key");

endmodule

// File: verilog/key_words.sv
/*
 * One pair of expanded key words K(2i), K(2i+1) for pair index i.
 * Only pair indices below 128 are meaningful, the core uses 0..19.
 */
`timescale 1ns/1ps

module key_words import twofish_pkg::*; (
    input  round_idx_t pair_idx,
    input  sbox_key_t  keys,
    output round_key_t rk
);

    word_t x_even;
    word_t x_odd;
    word_t a;
    word_t h_odd;
    word_t b;
    word_t sum_2b;

    // 2i replicated into every byte, then 2i+1
    assign x_even = {4{pair_idx[6:0], 1'b0}};
    assign x_odd  = x_even + 32'h0101_0101;

    h_function i_h_even (
        .x(x_even),
        .l1(keys.me1),
        .l0(keys.me0),
        .z(a)
    );

    h_function i_h_odd (
        .x(x_odd),
        .l1(keys.mo1),
        .l0(keys.mo0),
        .z(h_odd)
    );

    assign b      = {h_odd[23:0], h_odd[31:24]};
    assign sum_2b = a + {b[30:0], 1'b0};

    // odd word gets a rotate left by 9
    assign rk = '{k_even: a + b, k_odd: {sum_2b[22:0], sum_2b[31:23]}};

endmodule

// File: verilog/h_function.sv
/*
 * Twofish h function for a two-word key list (128-bit keys only).
 * l1 is mixed in after the first q layer, l0 after the second.
 */
`timescale 1ns/1ps

module h_function import twofish_pkg::*; (
    input  word_t x,
    input  word_t l1,
    input  word_t l0,
    output word_t z
);

    // bit i selects q1 for byte lane i
    localparam logic [3:0] SEL_A = 4'b1010;
    localparam logic [3:0] SEL_B = 4'b1100;
    localparam logic [3:0] SEL_C = 4'b0101;

    word_t qa;
    word_t qb;
    word_t qc;
    word_t xa;
    word_t xb;

    assign xa = qa ^ l1;
    assign xb = qb ^ l0;

    for (genvar i = 0; i < 4; i++) begin : g_lane
        q_permute #(.q_sel(SEL_A[i])) i_q_a (
            .x(x[8*i +: 8]),
            .y(qa[8*i +: 8])
        );
        q_permute #(.q_sel(SEL_B[i])) i_q_b (
            .x(xa[8*i +: 8]),
            .y(qb[8*i +: 8])
        );
        q_permute #(.q_sel(SEL_C[i])) i_q_c (
            .x(xb[8*i +: 8]),
            .y(qc[8*i +: 8])
        );
    end

    // MDS multiply, output byte r is row r times the byte vector
    always_comb begin
        z = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                z[8*r +: 8] = z[8*r +: 8] ^ gf_mul(MDS[r][c], qc[8*c +: 8], MDS_POLY);
            end
        end
    end

endmodule

// File: verilog/q_permute.sv
/*
 * Twofish byte permutation q0 or q1, chosen at elaboration by q_sel.
 * Purely combinational.
 */
`timescale 1ns/1ps

module q_permute import twofish_pkg::*; #(
    parameter bit q_sel = 1'b0
) (
    input  logic [7:0] x,
    output logic [7:0] y
);

    logic [3:0] a0, b0;
    logic [3:0] a1, b1;
    logic [3:0] a2, b2;
    logic [3:0] a3, b3;
    logic [3:0] a4, b4;

    // a ^ ror4(b, 1) ^ (8a mod 16)
    function automatic logic [3:0] mix(input logic [3:0] a, input logic [3:0] b);
        return a ^ {b[0], b[3:1]} ^ {a[0], 3'b000};
    endfunction

    always_comb begin
        a0 = x[7:4];
        b0 = x[3:0];
        a1 = a0 ^ b0;
        b1 = mix(a0, b0);
        a2 = q_sel ? Q1_T0[a1] : Q0_T0[a1];
        b2 = q_sel ? Q1_T1[b1] : Q0_T1[b1];
        a3 = a2 ^ b2;
        b3 = mix(a2, b2);
        a4 = q_sel ? Q1_T2[a3] : Q0_T2[a3];
        b4 = q_sel ? Q1_T3[b3] : Q0_T3[b3];
    end

    assign y = {b4, a4};

endmodule

// File: verilog/twofish_pkg.sv
/*
 * Shared types and helpers for the 128-bit key Twofish core.
 * Byte 0 of a standard byte stream sits in bits 7:0 of every word and block.
 */
package twofish_pkg;

    typedef logic [31:0]  word_t;
    typedef logic [127:0] key_t;
    typedef logic [7:0]   round_idx_t;

    // r0 in the low bits
    typedef struct packed {
        word_t r3;
        word_t r2;
        word_t r1;
        word_t r0;
    } block_t;

    // me/mo are the even/odd key words, s1 feeds the first h key layer
    typedef struct packed {
        word_t me1;
        word_t me0;
        word_t mo1;
        word_t mo0;
        word_t s1;
        word_t s0;
    } sbox_key_t;

    typedef struct packed {
        word_t k7;
        word_t k6;
        word_t k5;
        word_t k4;
        word_t k3;
        word_t k2;
        word_t k1;
        word_t k0;
    } whiten_t;

    typedef struct packed {
        word_t k_even;
        word_t k_odd;
    } round_key_t;

    localparam logic [8:0] MDS_POLY       = 9'h169;
    localparam logic [8:0] RS_POLY        = 9'h14D;
    // round 0 uses key pair 4, pairs 0..3 are whitening
    localparam round_idx_t ROUND_KEY_BASE = 8'd4;

    `include "twofish_tables.svh"

    // shift-and-add multiply in GF(2^8)
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b,
                                          input logic [8:0] poly);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = sh[7] ? ((sh << 1) ^ poly[7:0]) : (sh << 1);
        end
        return acc;
    endfunction

endpackage

// File: include/twofish_tables.svh
/*
 * Twofish constant tables, pulled into twofish_pkg by include.
 * Nibble tables are indexed 0..15 in listed order, matrices are row major.
 */
`ifndef TWOFISH_TABLES_SVH
`define TWOFISH_TABLES_SVH

// q0 nibble tables
localparam logic [3:0] Q0_T0 [16] = '{4'h8, 4'h1, 4'h7, 4'hD, 4'h6, 4'hF, 4'h3, 4'h2,
                                      4'h0, 4'hB, 4'h5, 4'h9, 4'hE, 4'hC, 4'hA, 4'h4};
localparam logic [3:0] Q0_T1 [16] = '{4'hE, 4'hC, 4'hB, 4'h8, 4'h1, 4'h2, 4'h3, 4'h5,
                                      4'hF, 4'h4, 4'hA, 4'h6, 4'h7, 4'h0, 4'h9, 4'hD};
localparam logic [3:0] Q0_T2 [16] = '{4'hB, 4'hA, 4'h5, 4'hE, 4'h6, 4'hD, 4'h9, 4'h0,
                                      4'hC, 4'h8, 4'hF, 4'h3, 4'h2, 4'h4, 4'h7, 4'h1};
localparam logic [3:0] Q0_T3 [16] = '{4'hD, 4'h7, 4'hF, 4'h4, 4'h1, 4'h2, 4'h6, 4'hE,
                                      4'h9, 4'hB, 4'h3, 4'h0, 4'h8, 4'h5, 4'hC, 4'hA};

// q1 nibble tables
localparam logic [3:0] Q1_T0 [16] = '{4'h2, 4'h8, 4'hB, 4'hD, 4'hF, 4'h7, 4'h6, 4'hE,
                                      4'h3, 4'h1, 4'h9, 4'h4, 4'h0, 4'hA, 4'hC, 4'h5};
localparam logic [3:0] Q1_T1 [16] = '{4'h1, 4'hE, 4'h2, 4'hB, 4'h4, 4'hC, 4'h3, 4'h7,
                                      4'h6, 4'hD, 4'hA, 4'h5, 4'hF, 4'h9, 4'h0, 4'h8};
localparam logic [3:0] Q1_T2 [16] = '{4'h4, 4'hC, 4'h7, 4'h5, 4'h1, 4'h6, 4'h9, 4'hA,
                                      4'h0, 4'hE, 4'hD, 4'h8, 4'h2, 4'hB, 4'h3, 4'hF};
localparam logic [3:0] Q1_T3 [16] = '{4'hB, 4'h9, 4'h5, 4'h1, 4'hC, 4'h3, 4'hD, 4'hE,
                                      4'h6, 4'h4, 4'h7, 4'hF, 4'h2, 4'h0, 4'h8, 4'hA};

// MDS matrix, applied to the four h output bytes
localparam logic [7:0] MDS [4][4] = '{'{8'h01, 8'hEF, 8'h5B, 8'h5B},
                                      '{8'h5B, 8'hEF, 8'hEF, 8'h01},
                                      '{8'hEF, 8'h5B, 8'h01, 8'hEF},
                                      '{8'hEF, 8'h01, 8'hEF, 8'h5B}};

// Reed-Solomon matrix, applied to eight key bytes
localparam logic [7:0] RS [4][8] = '{
    '{8'h01, 8'hA4, 8'h55, 8'h87, 8'h5A, 8'h58, 8'hDB, 8'h9E},
    '{8'hA4, 8'h56, 8'h82, 8'hF3, 8'h1E, 8'hC6, 8'h68, 8'hE5},
    '{8'h02, 8'hA1, 8'hFC, 8'hC1, 8'h47, 8'hAE, 8'h3D, 8'h19},
    '{8'hA4, 8'h55, 8'h87, 8'h5A, 8'h58, 8'hDB, 8'h9E, 8'h03}
};

`endif
